//--- logic/tracker_pkg.sv
package tracker_pkg;

	// Blob record in frame memory, RECORD_WORDS words per blob
	//   word 0: colour code plus one in bits 7:0, code 0 means no recognized colour
	//   word 1: area in bits 15:0, height in bits 23:16
	//   word 2: centroid x in bits 31:24, y in bits 23:16, size in bits 15:0
	localparam int NUM_COLORS    = 6;
	localparam int NUM_RANKS     = 3;
	localparam int NUM_REPORTS   = 6;
	localparam int RECORD_WORDS  = 3;
	localparam int WORD_SHAPE    = 1;	// Area and height
	localparam int WORD_CENTROID = 2;
	localparam int MAX_HEIGHT    = 120;	// Taller blobs rank as height 0
	localparam int ADDR_W        = 18;
	localparam int DATA_W        = 32;
	localparam logic [ADDR_W-1:0] RECORD_BASE = 18'h00100;	// Address of record 0

	typedef logic [ADDR_W-1:0] mem_addr_t;
	typedef logic [DATA_W-1:0] mem_data_t;
	typedef logic [15:0]       blob_metric_t;
	typedef logic [15:0]       blob_index_t;
	typedef logic [2:0]        color_t;
	typedef logic [7:0]        coord_t;

	typedef enum logic {select_biggest, select_highest} select_mode_t;
	typedef enum logic {report_per_color, report_two_colors} report_mode_t;
	typedef enum logic [1:0] {scan_idle, scan_color, scan_shape, scan_finished} scan_state_t;
	typedef enum logic [2:0] {
		rep_idle, rep_select, rep_read, rep_write, rep_finished
	} report_state_t;
	typedef enum logic [1:0] {apb_idle, apb_setup, apb_access} apb_state_t;

	typedef struct packed {
		logic      valid;
		logic      write;
		mem_addr_t addr;
		mem_data_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic      done;	// One cycle per finished transfer
		mem_data_t rdata;
	} mem_rsp_t;

	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		mem_addr_t paddr;
		mem_data_t pwdata;
	} apb_req_t;

	typedef struct packed {
		blob_metric_t metric;	// Zero marks an empty slot
		blob_index_t  index;
	} rank_entry_t;

	typedef struct packed {
		logic         valid;
		color_t       color;
		blob_metric_t metric;
		blob_index_t  index;
	} candidate_t;

	// Same bit layout as record word 2
	typedef struct packed {
		coord_t       x;
		coord_t       y;
		blob_metric_t size;
	} centroid_t;

endpackage

//--- logic/blob_scanner.sv
`timescale 1ns/1ps

module blob_scanner (
	input  logic                      crystal_clk_div_by_two,
	input  logic                      reset,
	input  logic                      start,
	input  tracker_pkg::select_mode_t select_mode,
	input  tracker_pkg::blob_index_t  blob_count,
	output tracker_pkg::mem_req_t     mem_req,
	input  tracker_pkg::mem_rsp_t     mem_rsp,
	output tracker_pkg::candidate_t   candidate,
	output logic                      scan_done
);
	import tracker_pkg::*;

	scan_state_t  state;
	blob_index_t  index;
	mem_addr_t    record_addr;	// Word 0 of the current record
	color_t       color;
	blob_metric_t metric;
	logic         no_color;
	logic         last_record;
	logic         advance;

	assign no_color    = (mem_rsp.rdata[7:0] == 8'd0);
	assign last_record = (index == blob_count - 1'b1);
	assign advance     = mem_rsp.done && ((state == scan_shape) || no_color);
	assign scan_done   = (state == scan_finished);

	// Ranking metric from word 1
	always_comb begin
		if (select_mode == select_highest) begin
			metric = blob_metric_t'(mem_rsp.rdata[23:16]);
			if (metric > MAX_HEIGHT)
				metric = '0;	// Out of the frame
		end else begin
			metric = mem_rsp.rdata[15:0];
		end
	end

	always_comb begin
		mem_req.valid = (state == scan_color) || (state == scan_shape);
		mem_req.write = 1'b0;
		mem_req.addr  = (state == scan_shape) ? record_addr + mem_addr_t'(WORD_SHAPE) : record_addr;
		mem_req.wdata = '0;
	end

	always_ff @(posedge crystal_clk_div_by_two) begin
		candidate.valid <= 1'b0;	// Single cycle pulse
		if (reset || !start) begin
			state <= scan_idle;
		end else begin
			case (state)
				scan_idle: begin
					index       <= '0;
					record_addr <= RECORD_BASE;
					state       <= (blob_count == '0) ? scan_finished : scan_color;
				end
				scan_color: begin
					if (mem_rsp.done && !no_color) begin
						color <= color_t'(mem_rsp.rdata[7:0] - 8'd1);	// Stored offset by one
						state <= scan_shape;
					end
				end
				scan_shape: begin
					if (mem_rsp.done) begin
						candidate.valid  <= 1'b1;
						candidate.color  <= color;
						candidate.metric <= metric;
						candidate.index  <= index;
					end
				end
				default: ;
			endcase
			// Next record, or finish after the last one
			if (advance) begin
				index       <= index + 1'b1;
				record_addr <= record_addr + mem_addr_t'(RECORD_WORDS);
				state       <= last_record ? scan_finished : scan_color;
			end
		end
	end

endmodule

//--- logic/blob_rank_table.sv
`timescale 1ns/1ps

module blob_rank_table (
	input  logic                      crystal_clk_div_by_two,
	input  logic                      reset,
	input  logic                      start,
	input  tracker_pkg::blob_metric_t minimum_blob_size,
	input  tracker_pkg::candidate_t   candidate,
	output tracker_pkg::rank_entry_t  entries [tracker_pkg::NUM_COLORS][tracker_pkg::NUM_RANKS]
);
	import tracker_pkg::*;

	color_t                 row;
	logic                   accept;
	logic [NUM_RANKS-1:0]   beats;	// Candidate strictly above this rank
	rank_entry_t            fresh;

	assign row    = (candidate.color < NUM_COLORS) ? candidate.color : '0;
	assign accept = candidate.valid && (candidate.color < NUM_COLORS) &&
			(candidate.metric > minimum_blob_size);
	assign fresh  = '{metric: candidate.metric, index: candidate.index};

	// Rows stay sorted, so beats is a run of ones from the bottom up
	always_comb begin
		for (int r = 0; r < NUM_RANKS; r++) begin
			beats[r] = candidate.metric > entries[row][r].metric;
		end
	end

	always_ff @(posedge crystal_clk_div_by_two) begin
		if (reset || !start) begin
			for (int c = 0; c < NUM_COLORS; c++) begin
				for (int r = 0; r < NUM_RANKS; r++) begin
					entries[c][r] <= '0;
				end
			end
		end else if (accept) begin
			if (beats[0])
				entries[row][0] <= fresh;
			// Shift down below the insert point, ties stay put
			for (int r = 1; r < NUM_RANKS; r++) begin
				if (beats[r])
					entries[row][r] <= beats[r-1] ? entries[row][r-1] : fresh;
			end
		end
	end

endmodule

//--- logic/centroid_reporter.sv
`timescale 1ns/1ps

module centroid_reporter (
	input  logic                      crystal_clk_div_by_two,
	input  logic                      reset,
	input  logic                      start,
	input  logic                      scan_done,
	input  tracker_pkg::report_mode_t report_mode,
	input  tracker_pkg::rank_entry_t  entries [tracker_pkg::NUM_COLORS][tracker_pkg::NUM_RANKS],
	output tracker_pkg::mem_req_t     mem_req,
	input  tracker_pkg::mem_rsp_t     mem_rsp,
	output tracker_pkg::centroid_t    centroids [tracker_pkg::NUM_REPORTS],
	output logic                      done
);
	import tracker_pkg::*;

	report_state_t state;
	logic [2:0]    slot;
	color_t        slot_color;
	logic [1:0]    slot_rank;
	rank_entry_t   slot_entry;
	logic          last_slot;
	mem_addr_t     addr;
	mem_data_t     cleared;	// Centroid word with size zeroed

	// Slot to table position
	always_comb begin
		if (report_mode == report_two_colors) begin
			slot_color = (slot < 3'(NUM_RANKS)) ? 3'd0 : 3'd1;
			slot_rank  = (slot < 3'(NUM_RANKS)) ? slot[1:0] : 2'(slot - 3'(NUM_RANKS));
		end else begin
			slot_color = color_t'(slot);
			slot_rank  = '0;
		end
		slot_entry = entries[slot_color][slot_rank];
	end

	assign last_slot = (slot == 3'(NUM_REPORTS - 1));
	assign done      = (state == rep_finished) && start;

	always_comb begin
		mem_req.valid = (state == rep_read) || (state == rep_write);
		mem_req.write = (state == rep_write);
		mem_req.addr  = addr;
		mem_req.wdata = cleared;
	end

	always_ff @(posedge crystal_clk_div_by_two) begin
		if (reset || !start) begin
			state <= rep_idle;
			slot  <= '0;
			for (int i = 0; i < NUM_REPORTS; i++) begin
				centroids[i] <= '0;
			end
		end else begin
			case (state)
				rep_idle: begin
					if (scan_done)
						state <= rep_select;
				end
				rep_select: begin
					if (slot_entry.metric == '0) begin	// Empty, no access
						slot  <= slot + 1'b1;
						state <= last_slot ? rep_finished : rep_select;
					end else begin
						addr  <= mem_addr_t'(RECORD_BASE + slot_entry.index * RECORD_WORDS +
								WORD_CENTROID);
						state <= rep_read;
					end
				end
				rep_read: begin
					if (mem_rsp.done) begin
						centroids[slot] <= centroid_t'(mem_rsp.rdata);
						cleared         <= {mem_rsp.rdata[31:16], 16'h0000};
						state           <= rep_write;
					end
				end
				rep_write: begin
					if (mem_rsp.done) begin
						slot  <= slot + 1'b1;
						state <= last_slot ? rep_finished : rep_select;
					end
				end
				default: ;	// Hold until start drops
			endcase
		end
	end

endmodule

//--- logic/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
	input  logic                   crystal_clk_div_by_two,
	input  logic                   reset,
	input  tracker_pkg::mem_req_t  scan_req,
	output tracker_pkg::mem_rsp_t  scan_rsp,
	input  tracker_pkg::mem_req_t  report_req,
	output tracker_pkg::mem_rsp_t  report_rsp,
	output tracker_pkg::apb_req_t  apb,
	input  tracker_pkg::mem_data_t prdata,
	input  logic                   pready
);
	import tracker_pkg::*;

	apb_state_t state;	// Registered, idle or access
	apb_state_t phase;	// Bus phase of this cycle
	logic       owner;	// High for the reporter
	logic       owner_q;
	logic       owner_valid;
	logic       stale;	// Owner gave up during access
	logic       xfer_done;
	mem_req_t   sel_req;
	mem_req_t   held;	// Fields frozen for the access phase
	mem_req_t   fields;

	// Setup starts in the same cycle as the request
	always_comb begin
		if (state == apb_access)
			phase = apb_access;
		else if (scan_req.valid || report_req.valid)
			phase = apb_setup;
		else
			phase = apb_idle;
	end

	assign owner       = (phase == apb_setup) ? !scan_req.valid : owner_q;	// Scanner first
	assign sel_req     = owner ? report_req : scan_req;
	assign fields      = (state == apb_access) ? held : sel_req;
	assign owner_valid = owner_q ? report_req.valid : scan_req.valid;
	assign xfer_done   = (state == apb_access) && pready && owner_valid && !stale;

	always_comb begin
		apb.psel    = (phase != apb_idle);
		apb.penable = (phase == apb_access);
		apb.pwrite  = fields.write;
		apb.paddr   = fields.addr;
		apb.pwdata  = fields.wdata;
	end

	assign scan_rsp.done     = xfer_done && !owner_q;
	assign scan_rsp.rdata    = prdata;
	assign report_rsp.done   = xfer_done && owner_q;
	assign report_rsp.rdata  = prdata;

	always_ff @(posedge crystal_clk_div_by_two) begin
		if (reset) begin
			state   <= apb_idle;
			owner_q <= 1'b0;
			stale   <= 1'b0;
		end else begin
			case (phase)
				apb_setup: begin
					state   <= apb_access;
					owner_q <= owner;
					stale   <= 1'b0;
				end
				apb_access: begin
					if (pready)
						state <= apb_idle;	// Transfer ends even after an abort
					if (!owner_valid)
						stale <= 1'b1;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge crystal_clk_div_by_two) begin
		if (phase == apb_setup)
			held <= sel_req;
	end

endmodule

//--- logic/blob_tracker_top.sv
`timescale 1ns/1ps

module blob_tracker_top (
	input  logic                      crystal_clk_div_by_two,
	input  logic                      reset,
	input  logic                      start,
	input  tracker_pkg::select_mode_t select_mode,
	input  tracker_pkg::report_mode_t report_mode,
	input  tracker_pkg::blob_metric_t minimum_blob_size,
	input  tracker_pkg::blob_index_t  blob_count,
	output tracker_pkg::apb_req_t     apb,
	input  tracker_pkg::mem_data_t    prdata,
	input  logic                      pready,
	output tracker_pkg::centroid_t    centroids [tracker_pkg::NUM_REPORTS],
	output logic                      done
);
	import tracker_pkg::*;

	mem_req_t    scan_req;
	mem_req_t    report_req;
	mem_rsp_t    scan_rsp;
	mem_rsp_t    report_rsp;
	candidate_t  candidate;
	rank_entry_t entries [NUM_COLORS][NUM_RANKS];
	logic        scan_done;

	blob_scanner u_scanner (
		.crystal_clk_div_by_two (crystal_clk_div_by_two),
		.reset                  (reset),
		.start                  (start),
		.select_mode            (select_mode),
		.blob_count             (blob_count),
		.mem_req                (scan_req),
		.mem_rsp                (scan_rsp),
		.candidate              (candidate),
		.scan_done              (scan_done)
	);

	blob_rank_table u_rank_table (
		.crystal_clk_div_by_two (crystal_clk_div_by_two),
		.reset                  (reset),
		.start                  (start),
		.minimum_blob_size      (minimum_blob_size),
		.candidate              (candidate),
		.entries                (entries)
	);

	centroid_reporter u_reporter (
		.crystal_clk_div_by_two (crystal_clk_div_by_two),
		.reset                  (reset),
		.start                  (start),
		.scan_done              (scan_done),
		.report_mode            (report_mode),
		.entries                (entries),
		.mem_req                (report_req),
		.mem_rsp                (report_rsp),
		.centroids              (centroids),
		.done                   (done)
	);

	mem_arbiter u_arbiter (
		.crystal_clk_div_by_two (crystal_clk_div_by_two),
		.reset                  (reset),
		.scan_req               (scan_req),
		.scan_rsp               (scan_rsp),
		.report_req             (report_req),
		.report_rsp             (report_rsp),
		.apb                    (apb),
		.prdata                 (prdata),
		.pready                 (pready)
	);

endmodule

//--- dv/blob_tracker_checker.sv
`timescale 1ns/1ps

module blob_tracker_checker (
	input logic                  crystal_clk_div_by_two,
	input logic                  reset,
	input tracker_pkg::apb_req_t apb,
	input logic                  pready,
	input logic                  done
);

	// Setup lasts exactly one cycle
	setup_to_access: assert property (@(posedge crystal_clk_div_by_two) disable iff (reset)
		apb.psel && !apb.penable |=> apb.psel && apb.penable)
		else $error("APB setup phase not followed by access");

	hold_while_waiting: assert property (@(posedge crystal_clk_div_by_two) disable iff (reset)
		apb.penable && !pready |=> apb.penable && $stable(apb.paddr) &&
		$stable(apb.pwrite) && $stable(apb.pwdata))
		else $error("APB fields changed while waiting for pready");

	enable_with_select: assert property (@(posedge crystal_clk_div_by_two) disable iff (reset)
		apb.penable |-> apb.psel)
		else $error("penable high without psel");

	// Bus and done quiet after reset
	quiet_after_reset: assert property (@(posedge crystal_clk_div_by_two)
		reset |=> !done && !apb.psel)
		else $error("done or psel high after reset");

endmodule

//--- dv/tb_blob_tracker.sv
`timescale 1ns/1ps

module tb_blob_tracker;
	import tracker_pkg::*;

	localparam int CLK_PERIOD  = 20;
	localparam int MAX_REC     = 16;
	localparam int REGION_LO   = int'(RECORD_BASE) - 16;
	localparam int REGION_HI   = int'(RECORD_BASE) + RECORD_WORDS * MAX_REC + 15;
	localparam int RUNS        = 8;
	localparam int ACCESS_MAX  = 2 * MAX_REC + 2 * NUM_REPORTS;	// Per run
	localparam int WATCHDOG_NS = (RUNS * ACCESS_MAX * 40 + 1000) * CLK_PERIOD;

	logic         crystal_clk_div_by_two;
	logic         reset;
	logic         start;
	select_mode_t select_mode;
	report_mode_t report_mode;
	blob_metric_t minimum_blob_size;
	blob_index_t  blob_count;
	apb_req_t     apb;
	mem_data_t    prdata;
	logic         pready;
	centroid_t    centroids [NUM_REPORTS];
	logic         done;

	mem_data_t    mem    [2**ADDR_W];
	mem_data_t    golden [2**ADDR_W];	// Expected memory contents
	logic [31:0]  lfsr = 32'd81382;
	logic         random_ready = 1'b0;
	int           rec_n;
	logic [7:0]   rec_code   [MAX_REC];
	blob_metric_t rec_area   [MAX_REC];
	logic [7:0]   rec_height [MAX_REC];
	mem_data_t    rec_cent   [MAX_REC];
	centroid_t    expected   [NUM_REPORTS];

	blob_tracker_top DUT (.*);

	bind blob_tracker_top blob_tracker_checker u_checker (.*);

	initial begin
		crystal_clk_div_by_two = 1'b0;
		forever #(CLK_PERIOD / 2) crystal_clk_div_by_two = ~crystal_clk_div_by_two;
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic mem_data_t fill_word(input int a);
		return {~a[13:0], a[17:0]};
	endfunction

	task automatic fail_run(input string what);
		$display("Regression failed");
		$fatal(1, "%s", what);
	endtask

	task automatic check_centroid(input string name, input centroid_t actual,
			input centroid_t want);
		if (actual !== want) begin
			$display("[ERROR] t=%0t %s: got x=%0d y=%0d size=%0d, expected x=%0d y=%0d size=%0d",
				$time, name, actual.x, actual.y, actual.size, want.x, want.y, want.size);
			fail_run("centroid mismatch");
		end
	endtask

	task automatic check_word(input string name, input mem_data_t actual, input mem_data_t want);
		if (actual !== want) begin
			$display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, actual, want);
			fail_run("memory word mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic want);
		if (actual !== want) begin
			$display("[ERROR] t=%0t %s: got %b, expected %b", $time, name, actual, want);
			fail_run("flag mismatch");
		end
	endtask

	// APB memory, one LFSR bit per cycle when wait states are on
	always @(posedge crystal_clk_div_by_two) begin
		if (random_ready) begin
			lfsr = lfsr_next(lfsr);
			pready <= lfsr[0];
		end else begin
			pready <= 1'b1;
		end
		if (apb.psel)
			prdata <= mem[apb.paddr];
		if (apb.psel && apb.penable && pready && apb.pwrite) begin
			if (int'(apb.paddr) < REGION_LO || int'(apb.paddr) > REGION_HI)
				fail_run("DUT wrote outside the record area");
			else
				mem[apb.paddr] <= apb.pwdata;
		end
	end

	task automatic add_record(input logic [7:0] code, input blob_metric_t area,
			input logic [7:0] height, input coord_t x, input coord_t y, input blob_metric_t size);
		rec_code[rec_n]   = code;
		rec_area[rec_n]   = area;
		rec_height[rec_n] = height;
		rec_cent[rec_n]   = {x, y, size};
		rec_n++;
	endtask

	task automatic put_word(input mem_addr_t addr, input mem_data_t data);
		mem[addr]    <= data;
		golden[addr] = data;
	endtask

	task automatic load_records();
		mem_addr_t base;
		for (int i = 0; i < rec_n; i++) begin
			base = RECORD_BASE + mem_addr_t'(i * RECORD_WORDS);
			put_word(base, {24'h000000, rec_code[i]});
			put_word(base + 18'd1, {8'h00, rec_height[i], rec_area[i]});
			put_word(base + 18'd2, rec_cent[i]);
		end
		@(posedge crystal_clk_div_by_two);
	endtask

	// Top three per colour, first arrival wins a tie
	task automatic build_expected(input select_mode_t sel, input report_mode_t rmode,
			input blob_metric_t minimum);
		int unsigned best_metric [NUM_COLORS][NUM_RANKS];
		int          best_index  [NUM_COLORS][NUM_RANKS];
		int unsigned m;
		int          c;
		int          r;
		int          pos;
		mem_addr_t   addr;
		best_metric = '{default: 0};
		best_index  = '{default: 0};
		for (int i = 0; i < rec_n; i++) begin
			if (rec_code[i] == 8'd0 || int'(rec_code[i]) > NUM_COLORS)
				continue;
			c = int'(rec_code[i]) - 1;
			if (sel == select_highest)
				m = (int'(rec_height[i]) > MAX_HEIGHT) ? 0 : 32'(rec_height[i]);
			else
				m = 32'(rec_area[i]);
			if (m <= 32'(minimum))
				continue;
			pos = NUM_RANKS;
			for (int k = NUM_RANKS - 1; k >= 0; k--)
				if (m > best_metric[c][k])
					pos = k;
			for (int k = NUM_RANKS - 1; k > pos; k--) begin
				best_metric[c][k] = best_metric[c][k-1];
				best_index[c][k]  = best_index[c][k-1];
			end
			if (pos < NUM_RANKS) begin
				best_metric[c][pos] = m;
				best_index[c][pos]  = i;
			end
		end
		for (int s = 0; s < NUM_REPORTS; s++) begin
			c = (rmode == report_two_colors) ? s / NUM_RANKS : s;
			r = (rmode == report_two_colors) ? s % NUM_RANKS : 0;
			expected[s] = '0;
			if (best_metric[c][r] != 0) begin
				expected[s]  = centroid_t'(rec_cent[best_index[c][r]]);
				addr         = RECORD_BASE + mem_addr_t'(best_index[c][r] * RECORD_WORDS + 2);
				golden[addr] = {rec_cent[best_index[c][r]][31:16], 16'h0000};	// Size cleared
			end
		end
	endtask

	task automatic launch(input select_mode_t sel, input report_mode_t rmode,
			input blob_metric_t minimum);
		@(posedge crystal_clk_div_by_two);
		select_mode       <= sel;
		report_mode       <= rmode;
		minimum_blob_size <= minimum;
		blob_count        <= blob_index_t'(rec_n);
		start             <= 1'b1;
	endtask

	// Done and every centroid back at zero once start is low
	task automatic check_cleared();
		check_flag("done", done, 1'b0);
		for (int s = 0; s < NUM_REPORTS; s++)
			check_centroid($sformatf("centroids[%0d]", s), centroids[s], '0);
	endtask

	task automatic run_case(input select_mode_t sel, input report_mode_t rmode,
			input blob_metric_t minimum);
		load_records();
		build_expected(sel, rmode, minimum);
		launch(sel, rmode, minimum);
		do @(posedge crystal_clk_div_by_two); while (!done);
		for (int s = 0; s < NUM_REPORTS; s++)
			check_centroid($sformatf("centroids[%0d]", s), centroids[s], expected[s]);
		for (int a = REGION_LO; a <= REGION_HI; a++)
			check_word($sformatf("mem[%h]", mem_addr_t'(a)), mem[a], golden[a]);
		@(posedge crystal_clk_div_by_two);
		start <= 1'b0;
		repeat (2) @(posedge crystal_clk_div_by_two);
		check_cleared();
	endtask

	// Drop start once the first centroid is latched, then rerun
	task automatic abort_case();
		load_records();
		launch(select_biggest, report_per_color, 16'd0);
		do @(posedge crystal_clk_div_by_two); while (centroids[0] == '0);
		start <= 1'b0;
		do @(posedge crystal_clk_div_by_two); while (apb.psel);	// In-flight transfer ends
		@(posedge crystal_clk_div_by_two);
		check_cleared();
		run_case(select_biggest, report_per_color, 16'd0);
	endtask

	// Colour 5 absent, ties, heights above the limit
	task automatic records_mixed();
		rec_n = 0;
		add_record(8'd1, 16'd300, 8'd40, 8'd10, 8'd20, 16'd300);
		add_record(8'd0, 16'd900, 8'd90, 8'd1, 8'd2, 16'd900);	// No colour
		add_record(8'd3, 16'd150, 8'd60, 8'd30, 8'd40, 16'd150);
		add_record(8'd1, 16'd500, 8'd10, 8'd50, 8'd60, 16'd500);
		add_record(8'd2, 16'd80, 8'd100, 8'd70, 8'd80, 16'd80);
		add_record(8'd3, 16'd150, 8'd121, 8'd110, 8'd120, 16'd150);
		add_record(8'd5, 16'd40, 8'd130, 8'd130, 8'd140, 16'd40);
		add_record(8'd4, 16'd700, 8'd200, 8'd150, 8'd160, 16'd700);
		add_record(8'd4, 16'd60, 8'd120, 8'd170, 8'd180, 16'd60);
	endtask

	task automatic records_ranked();
		rec_n = 0;
		add_record(8'd1, 16'd200, 8'd10, 8'd11, 8'd12, 16'd200);
		add_record(8'd1, 16'd50, 8'd10, 8'd13, 8'd14, 16'd50);	// At the minimum
		add_record(8'd2, 16'd90, 8'd10, 8'd15, 8'd16, 16'd90);
		add_record(8'd1, 16'd300, 8'd10, 8'd17, 8'd18, 16'd300);
		add_record(8'd1, 16'd200, 8'd10, 8'd19, 8'd20, 16'd200);
		add_record(8'd1, 16'd120, 8'd10, 8'd21, 8'd22, 16'd120);
		add_record(8'd2, 16'd51, 8'd10, 8'd23, 8'd24, 16'd51);
		add_record(8'd2, 16'd90, 8'd10, 8'd25, 8'd26, 16'd90);
		add_record(8'd3, 16'd999, 8'd10, 8'd27, 8'd28, 16'd999);
		add_record(8'd1, 16'd30, 8'd10, 8'd29, 8'd30, 16'd30);
	endtask

	initial begin
		reset             <= 1'b1;
		start             <= 1'b0;
		select_mode       <= select_biggest;
		report_mode       <= report_per_color;
		minimum_blob_size <= '0;
		blob_count        <= '0;
		prdata            <= '0;
		pready            <= 1'b1;
		for (int a = 0; a < 2**ADDR_W; a++) begin
			mem[a]    <= fill_word(a);
			golden[a] = fill_word(a);
		end
		repeat (8) @(posedge crystal_clk_div_by_two);
		reset <= 1'b0;
		@(posedge crystal_clk_div_by_two);
		for (int pass = 0; pass < 2; pass++) begin
			random_ready <= (pass == 1);	// Second pass with wait states
			records_mixed();
			run_case(select_biggest, report_per_color, 16'd0);
			run_case(select_highest, report_per_color, 16'd0);
			records_ranked();
			run_case(select_biggest, report_two_colors, 16'd50);
		end
		records_mixed();
		abort_case();
		$display("Regression passed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		fail_run("watchdog expired before the tests finished");
	end

endmodule

//--- compile.f
logic/tracker_pkg.sv
logic/blob_scanner.sv
logic/blob_rank_table.sv
logic/centroid_reporter.sv
logic/mem_arbiter.sv
logic/blob_tracker_top.sv
dv/blob_tracker_checker.sv
dv/tb_blob_tracker.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_blob_tracker
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Regression failed
PASS_MSG  ?= Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
